//--- Makefile
# kdf11 board simulation with Verilator

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module kdf11_tb -f verilog.f -Mdir obj_dir
	./obj_dir/Vkdf11_tb | tee sim.log
	grep -q "^PASS: all tests$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- common/kdf11_pkg.sv
/*
 * kdf11 board shared definitions
 * bus word and address types, the cpu master request,
 * i/o page register addresses and unibus map constants
 */
`default_nettype none

package kdf11_pkg;

  typedef logic [15:0] word_t;   // one bus data word
  typedef logic [21:0] paddr_t;  // 22-bit physical address
  typedef logic [17:0] uaddr_t;  // 18-bit unibus dma address

  // cpu master request as seen on the wishbone-style bus
  typedef struct packed {
    paddr_t     adr;  // physical address
    word_t      dat;  // write data
    logic       we;   // 1 = write
    logic [1:0] sel;  // byte lanes
    logic       stb;  // transfer strobe
    logic       ios;  // i/o page access
  } cpu_req_t;

  typedef logic [4:0] ubm_idx_t;  // map register number

  localparam ubm_idx_t ubm_page_c = 5'd31;  // unibus page wired to the i/o page

  // i/o page register addresses
  localparam word_t lks_adr_c  = 16'o177546;  // line clock status
  localparam word_t bdr_base_c = 16'o177520;  // pcr, maint, cdr

  // adr[12:7] of the map register window 170200-170377
  localparam logic [5:0] ubm_sel_c = 6'b100001;

  localparam int lks_ie_bit_c = 6;  // lks interrupt enable

endpackage

`default_nettype wire

//--- hw/bdr_regs.sv
/*
 * boot/diagnostic registers at 177520
 * pcr (two 4-bit halves), maintenance word, cdr with leds
 */
`timescale 1ns/1ps
`default_nettype none

module bdr_regs import kdf11_pkg::*; (
  input  logic       clk_p,
  input  logic       dclo,
  input  logic       init_i,   // bus reset
  input  logic       sel_i,
  input  cpu_req_t   req_i,
  output word_t      dat_o,
  output logic       ack_o,
  output logic [3:0] leds_o
);

  localparam word_t cdr_sw_c = 16'o000010;  // on-board switch image

  logic [3:0] pcr_l;  // low byte half
  logic [3:0] pcr_h;  // high byte half
  word_t      maint;
  logic [3:0] cdr;

  // ********************************************************************
  // register writes
  // ********************************************************************
  always_ff @(posedge clk_p or posedge dclo) begin
    if (dclo) begin
      pcr_l <= '0;
      pcr_h <= '0;
      maint <= '0;
      cdr   <= '0;
    end else if (sel_i && req_i.we) begin
      case (req_i.adr[2:1])
        2'b00: begin
          if (req_i.sel[0]) pcr_l <= req_i.dat[3:0];
          if (req_i.sel[1]) pcr_h <= req_i.dat[11:8];
        end
        2'b01: begin
          if (req_i.sel[0]) maint[7:0]  <= req_i.dat[7:0];
          if (req_i.sel[1]) maint[15:8] <= req_i.dat[15:8];
        end
        2'b10:   if (req_i.sel[0]) cdr <= req_i.dat[3:0];  // led control
        default: ;
      endcase
    end
  end

  // read data, valid with the ack
  always_ff @(posedge clk_p) begin
    if (sel_i && !req_i.we) begin
      case (req_i.adr[2:1])
        2'b00:   dat_o <= {4'b0, pcr_h, 4'b0, pcr_l};
        2'b01:   dat_o <= maint;
        2'b10:   dat_o <= cdr_sw_c;  // switches, not the led value
        default: dat_o <= '0;
      endcase
    end
  end

  // one-cycle reply per select
  always_ff @(posedge clk_p or posedge dclo) begin
    if (dclo) begin
      ack_o <= 1'b0;
    end else if (init_i) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= sel_i & ~ack_o;
    end
  end

  assign leds_o = cdr;

endmodule

`default_nettype wire

//--- hw/bus_control.sv
/*
 * bus control: dma grant flip-flop, memory/i-o strobe
 * steering and level 5/4 interrupt vector strobe priority
 */
`timescale 1ns/1ps
`default_nettype none

module bus_control import kdf11_pkg::*; (
  input  logic       clk_p,
  input  logic       dclo,
  input  cpu_req_t   cpu_req_i,
  input  logic       dma_req_i,
  input  logic       dma_stb_i,
  input  logic       cpu_istb_i,   // cpu asks for a vector
  input  logic [5:4] irq_i,
  input  logic [8:0] ivec_i,
  output logic       dma_ack_o,
  output logic       ram_stb_o,
  output logic       bus_stb_o,
  output logic [5:4] istb_o,
  output word_t      cpu_vec_o
);

  // grant only while the cpu is off the bus
  always_ff @(posedge clk_p or posedge dclo) begin
    if (dclo) begin
      dma_ack_o <= 1'b0;
    end else if (dma_req_i && !cpu_req_i.stb) begin
      dma_ack_o <= 1'b1;
    end else if (!dma_req_i) begin
      dma_ack_o <= 1'b0;  // release follows request drop
    end
  end

  // memory strobe belongs to the dma master during grant
  assign ram_stb_o = dma_ack_o ? dma_stb_i : (cpu_req_i.stb & ~cpu_req_i.ios);
  assign bus_stb_o = cpu_req_i.stb & cpu_req_i.ios & ~dma_ack_o;  // i/o page, cpu only

  // level 5 wins over level 4
  assign istb_o[5] = cpu_istb_i & irq_i[5];
  assign istb_o[4] = cpu_istb_i & irq_i[4] & ~irq_i[5];

  assign cpu_vec_o = {7'b0, ivec_i};  // 9-bit vector, zero extended

endmodule

`default_nettype wire

//--- hw/iopage_decode.sv
/*
 * i/o page decoder: device selects for lks, bdr and map
 * registers, read data mux and ack merge toward the cpu
 */
`timescale 1ns/1ps
`default_nettype none

module iopage_decode import kdf11_pkg::*; (
  input  logic   bus_stb_i,     // cpu i/o page strobe
  input  paddr_t adr_i,
  input  logic   dma_ack_i,
  input  logic   global_ack_i,  // external memory / devices
  input  word_t  wb_dat_i,
  input  word_t  lks_dat_i,
  input  word_t  bdr_dat_i,
  input  word_t  ubm_dat_i,
  input  logic   lks_ack_i,
  input  logic   bdr_ack_i,
  input  logic   ubm_ack_i,
  output logic   lks_sel_o,
  output logic   bdr_sel_o,
  output logic   ubm_sel_o,
  output word_t  cpu_dat_o,
  output logic   cpu_ack_o
);

  // ********************************************************************
  // device selects
  // ********************************************************************
  assign lks_sel_o = bus_stb_i & (adr_i[15:1] == lks_adr_c[15:1]);   // single word
  assign bdr_sel_o = bus_stb_i & (adr_i[15:3] == bdr_base_c[15:3]);  // 177520-177526
  assign ubm_sel_o = bus_stb_i & (adr_i[12:7] == ubm_sel_c);         // 170200-170377

  // internal devices only drive while selected
  assign cpu_dat_o = wb_dat_i
                   | (lks_sel_o ? lks_dat_i : '0)
                   | (bdr_sel_o ? bdr_dat_i : '0)
                   | (ubm_sel_o ? ubm_dat_i : '0);

  // cpu sees no reply while dma owns the bus
  assign cpu_ack_o = (global_ack_i | lks_ack_i | bdr_ack_i | ubm_ack_i) & ~dma_ack_i;

endmodule

`default_nettype wire

//--- hw/kdf11_board.sv
/*
 * kdf11 processor card glue logic
 * dma grant, interrupt priority, unibus map, boot/diag
 * registers, line clock and i/o page decoding
 */
`timescale 1ns/1ps
`default_nettype none

module kdf11_board import kdf11_pkg::*; #(
  parameter int line_period = 50  // clocks per line clock tick
) (
  input  logic       clk_p,
  input  logic       dclo,         // system reset
  // cpu master bus
  input  cpu_req_t   cpu_req_i,
  output word_t      cpu_dat_o,
  output logic       cpu_ack_o,
  // memory and device side
  output paddr_t     wb_adr_o,
  output logic       ram_stb_o,
  output logic       bus_stb_o,
  input  logic       global_ack_i,
  input  word_t      wb_dat_i,
  // dma master
  input  logic       dma_req_i,
  input  uaddr_t     dma_adr18_i,
  input  logic       dma_stb_i,
  output logic       dma_ack_o,
  // interrupts
  input  logic [5:4] irq_i,
  input  logic [8:0] ivec_i,
  input  logic       cpu_istb_i,
  input  logic       cpu_init_i,   // bus reset from cpu
  output logic [5:4] istb_o,
  output word_t      cpu_vec_o,
  output logic       evnt_o,       // line clock interrupt
  input  logic       umap_i,       // unibus map enable
  output logic [3:0] leds_o
);

  logic  bus_init;  // bus reset, also held during dclo
  logic  lks_sel, bdr_sel, ubm_sel;
  logic  lks_ack, bdr_ack, ubm_ack;
  word_t lks_dat, bdr_dat, ubm_dat;

  assign bus_init = cpu_init_i | dclo;

  bus_control u_bus_control (
    .clk_p      (clk_p),
    .dclo       (dclo),
    .cpu_req_i  (cpu_req_i),
    .dma_req_i  (dma_req_i),
    .dma_stb_i  (dma_stb_i),
    .cpu_istb_i (cpu_istb_i),
    .irq_i      (irq_i),
    .ivec_i     (ivec_i),
    .dma_ack_o  (dma_ack_o),
    .ram_stb_o  (ram_stb_o),
    .bus_stb_o  (bus_stb_o),
    .istb_o     (istb_o),
    .cpu_vec_o  (cpu_vec_o)
  );

  iopage_decode u_iopage_decode (
    .bus_stb_i    (bus_stb_o),
    .adr_i        (wb_adr_o),
    .dma_ack_i    (dma_ack_o),
    .global_ack_i (global_ack_i),
    .wb_dat_i     (wb_dat_i),
    .lks_dat_i    (lks_dat),
    .bdr_dat_i    (bdr_dat),
    .ubm_dat_i    (ubm_dat),
    .lks_ack_i    (lks_ack),
    .bdr_ack_i    (bdr_ack),
    .ubm_ack_i    (ubm_ack),
    .lks_sel_o    (lks_sel),
    .bdr_sel_o    (bdr_sel),
    .ubm_sel_o    (ubm_sel),
    .cpu_dat_o    (cpu_dat_o),
    .cpu_ack_o    (cpu_ack_o)
  );

  ubm_map u_ubm_map (
    .clk_p       (clk_p),
    .init_i      (bus_init),
    .sel_i       (ubm_sel),
    .req_i       (cpu_req_i),
    .umap_i      (umap_i),
    .dma_ack_i   (dma_ack_o),
    .dma_adr18_i (dma_adr18_i),
    .dat_o       (ubm_dat),
    .ack_o       (ubm_ack),
    .wb_adr_o    (wb_adr_o)
  );

  bdr_regs u_bdr_regs (
    .clk_p  (clk_p),
    .dclo   (dclo),
    .init_i (bus_init),
    .sel_i  (bdr_sel),
    .req_i  (cpu_req_i),
    .dat_o  (bdr_dat),
    .ack_o  (bdr_ack),
    .leds_o (leds_o)
  );

  line_clock #(
    .line_period (line_period)
  ) u_line_clock (
    .clk_p  (clk_p),
    .init_i (bus_init),
    .sel_i  (lks_sel),
    .req_i  (cpu_req_i),
    .dat_o  (lks_dat),
    .ack_o  (lks_ack),
    .evnt_o (evnt_o)
  );

endmodule

`default_nettype wire

//--- hw/line_clock.sv
/*
 * line clock: divides clk_p to a tick every line_period
 * cycles, lks interrupt enable register at 177546
 */
`timescale 1ns/1ps
`default_nettype none

module line_clock import kdf11_pkg::*; #(
  parameter int line_period = 50
) (
  input  logic     clk_p,
  input  logic     init_i,  // bus reset
  input  logic     sel_i,
  input  cpu_req_t req_i,
  output word_t    dat_o,
  output logic     ack_o,
  output logic     evnt_o   // interrupt pulse to cpu
);

  localparam int cnt_w = (line_period > 1) ? $clog2(line_period) : 1;

  logic [cnt_w-1:0] cnt;
  logic             tick;
  logic             ie;    // interrupt enable

  // tick divider, wraps at line_period-1
  always_ff @(posedge clk_p) begin
    if (init_i) begin
      cnt  <= '0;
      tick <= 1'b0;
    end else if (cnt == cnt_w'(line_period - 1)) begin
      cnt  <= '0;
      tick <= 1'b1;
    end else begin
      cnt  <= cnt + 1'b1;
      tick <= 1'b0;
    end
  end

  // lks write and reply
  always_ff @(posedge clk_p) begin
    if (init_i) begin
      ie    <= 1'b0;
      ack_o <= 1'b0;
    end else begin
      if (sel_i && req_i.we && req_i.sel[0]) ie <= req_i.dat[lks_ie_bit_c];
      ack_o <= sel_i & ~ack_o;
    end
  end

  always_comb begin
    dat_o               = '0;
    dat_o[lks_ie_bit_c] = ie;  // only readable bit
  end

  assign evnt_o = tick & ie;

endmodule

`default_nettype wire

//--- test/kdf11_assert.sv
/*
 * kdf11 board protocol assertions
 * internal acks, dma strobe ownership, interrupt strobe priority
 */
`timescale 1ns/1ps
`default_nettype none

module kdf11_assert (
  input logic       clk_p,
  input logic       dclo,
  input logic       lks_sel_i,
  input logic       bdr_sel_i,
  input logic       ubm_sel_i,
  input logic       lks_ack_i,
  input logic       bdr_ack_i,
  input logic       ubm_ack_i,
  input logic       dma_ack_i,
  input logic       dma_stb_i,
  input logic       ram_stb_i,
  input logic [5:4] istb_i
);

  // a reply always follows its select by one cycle
  lks_ack_sel: assert property (@(posedge clk_p) disable iff (dclo) lks_ack_i |-> $past(lks_sel_i))
    else $error("lks ack without select");
  bdr_ack_sel: assert property (@(posedge clk_p) disable iff (dclo) bdr_ack_i |-> $past(bdr_sel_i))
    else $error("bdr ack without select");
  ubm_ack_sel: assert property (@(posedge clk_p) disable iff (dclo) ubm_ack_i |-> $past(ubm_sel_i))
    else $error("map ack without select");

  // memory strobe is the dma strobe during grant
  dma_owns_ram: assert property (@(posedge clk_p) disable iff (dclo)
                                 dma_ack_i |-> (ram_stb_i == dma_stb_i))
    else $error("cpu memory strobe during dma grant");

  istb_onehot: assert property (@(posedge clk_p) !(istb_i[5] && istb_i[4]))
    else $error("both interrupt strobes set");

endmodule

bind kdf11_board kdf11_assert u_assert (
  .clk_p     (clk_p),
  .dclo      (dclo),
  .lks_sel_i (lks_sel),
  .bdr_sel_i (bdr_sel),
  .ubm_sel_i (ubm_sel),
  .lks_ack_i (lks_ack),
  .bdr_ack_i (bdr_ack),
  .ubm_ack_i (ubm_ack),
  .dma_ack_i (dma_ack_o),
  .dma_stb_i (dma_stb_i),
  .ram_stb_i (ram_stb_o),
  .istb_i    (istb_o)
);

`default_nettype wire

//--- test/kdf11_checker.sv
/*
 * kdf11 board checker
 * watches the board outputs, compares them with expected values
 * and keeps the error counts
 */
`timescale 1ns/1ps
`default_nettype none

module kdf11_checker import kdf11_pkg::*; #(
  parameter int line_period = 20
) (
  input logic       clk_p,
  input logic       dclo,
  input word_t      cpu_dat_i,
  input logic       cpu_ack_i,
  input paddr_t     wb_adr_i,
  input logic       ram_stb_i,
  input logic       bus_stb_i,
  input logic       dma_ack_i,
  input logic [5:4] istb_i,
  input word_t      cpu_vec_i,
  input logic       evnt_i,
  input logic [3:0] leds_i
);

  int checks     = 0;
  int errors     = 0;   // from compares and faults
  int watch_errs = 0;   // from the clocked monitor
  int cyc        = 0;
  int evnt_cnt   = 0;
  int last_evnt  = -1;  // cycle of the previous pulse
  bit win_on     = 1'b0;

  task automatic compare(input string what, input paddr_t got, input paddr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic fault(input string msg);
    errors++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  // ********************************************************************
  // value checks called while the outputs are stable
  // ********************************************************************
  task automatic reset_state();
    // dma_ack, cpu_ack, istb, evnt, leds all low
    compare("outputs in reset", {13'b0, dma_ack_i, cpu_ack_i, istb_i, evnt_i, leds_i}, '0);
  endtask

  task automatic read_data(input word_t exp);
    compare("cpu_dat_o", {6'b0, cpu_dat_i}, {6'b0, exp});
  endtask

  task automatic dma_address(input paddr_t exp);
    compare("wb_adr_o", wb_adr_i, exp);
  endtask

  task automatic strobe_state(input logic exp_ram, input logic exp_bus);
    compare("ram_stb_o", {21'b0, ram_stb_i}, {21'b0, exp_ram});
    compare("bus_stb_o", {21'b0, bus_stb_i}, {21'b0, exp_bus});
  endtask

  task automatic irq_response(input logic [1:0] exp_istb, input word_t exp_vec);
    compare("istb_o", {20'b0, istb_i}, {20'b0, exp_istb});
    compare("cpu_vec_o", {6'b0, cpu_vec_i}, {6'b0, exp_vec});
  endtask

  task automatic led_state(input logic [3:0] exp);
    compare("leds_o", {18'b0, leds_i}, {18'b0, exp});
  endtask

  task automatic event_window_open();
    win_on = 1'b1;
  endtask

  task automatic event_window_close(input int exp);
    win_on = 1'b0;
    compare("evnt_o pulse count", 22'(evnt_cnt), 22'(exp));
  endtask

  function automatic int failures();
    return errors + watch_errs;
  endfunction

  task automatic report();
    $display("kdf11_checker: %0d checks, %0d errors", checks, errors + watch_errs);
  endtask

  // ********************************************************************
  // clocked monitor
  // ********************************************************************
  always @(posedge clk_p) begin
    cyc = cyc + 1;
    if (!dclo && dma_ack_i && cpu_ack_i) begin
      watch_errs++;
      $display("Mismatch at %0t: cpu_ack_o is 1 during the DMA grant, expected 0", $time);
    end
    if (!win_on) begin
      evnt_cnt  = 0;   // idle between windows
      last_evnt = -1;
    end else if (evnt_i) begin
      if (last_evnt >= 0 && cyc - last_evnt != line_period) begin
        watch_errs++;
        $display("Mismatch at %0t: evnt_o period %0d cycles, expected %0d",
                 $time, cyc - last_evnt, line_period);
      end
      evnt_cnt++;
      last_evnt = cyc;
    end
  end

endmodule

`default_nettype wire

//--- test/kdf11_golden.mem
// columns: op adr dat exp (hex)
// op 1/2/3 write word/low/high byte, 4 read, 5 dma (adr18, umap), 6 irq (irq5:4, ivec)
// op 7 line clock (periods, pulses), 8 leds
01 3fff52 1234 000000
04 3fff52 0000 001234
02 3fff52 00ab 000000
04 3fff52 0000 0012ab
03 3fff52 cd00 000000
04 3fff52 0000 00cdab
01 3fff50 0a05 000000
04 3fff50 0000 000a05
01 3fff50 ffff 000000
04 3fff50 0000 000f0f
03 3fff50 0300 000000
04 3fff50 0000 00030f
01 3fff54 0009 000000
08 000000 0000 000009
04 3fff54 0000 000008
01 3ff080 5677 000000
04 3ff080 0000 005676
01 3ff082 00e5 000000
04 3ff082 0000 000025
01 3ff08c 2001 000000
01 3ff08e 0003 000000
04 3ff08c 0000 002000
01 3ff0fc ffff 000000
04 3ff0fc 0000 00fffe
05 006abc 0001 032abc
05 000100 0001 255776
05 006abc 0000 006abc
05 03f234 0001 3ff234
05 03f234 0000 3ff234
06 000003 01f4 000002
06 000001 00bc 000001
06 000002 0100 000002
06 000000 0044 000000
01 3fff66 0040 000000
04 3fff66 0000 000040
07 000000 0004 000004
01 3fff66 0000 000000
04 3fff66 0000 000000
07 000000 0004 000000

//--- test/kdf11_tb.sv
/*
 * kdf11 board testbench
 * plays cpu, dma master and peripherals from the golden
 * transaction list, with a one-cycle memory responder
 */
`timescale 1ns/1ps
`default_nettype none

module kdf11_tb import kdf11_pkg::*; ();

  localparam int line_period = 20;
  localparam int max_ops     = 64;

  logic       clk_p = 1'b0;
  logic       dclo;
  cpu_req_t   cpu_req;
  word_t      cpu_dat;
  logic       cpu_ack;
  paddr_t     wb_adr;
  logic       ram_stb;
  logic       bus_stb;
  logic       global_ack = 1'b0;
  logic       ram_seen   = 1'b0;
  word_t      wb_dat;
  logic       dma_req;
  uaddr_t     dma_adr18;
  logic       dma_stb;
  logic       dma_ack;
  logic [5:4] irq;
  logic [8:0] ivec;
  logic       cpu_istb;
  logic       cpu_init;
  logic [5:4] istb;
  word_t      cpu_vec;
  logic       evnt;
  logic       umap;
  logic [3:0] leds;

  logic [23:0] golden [0:4*max_ops-1];  // op, adr, dat, exp per line
  int          cycles = 0;
  int          limit  = 0;

  always #4 clk_p = ~clk_p;  // 8 ns

  // memory side acks each strobe for one cycle
  always @(posedge clk_p) ram_seen <= ram_stb & ~global_ack;
  always @(negedge clk_p) global_ack <= ram_seen;

  kdf11_board #(
    .line_period (line_period)
  ) DUT (
    .clk_p        (clk_p),
    .dclo         (dclo),
    .cpu_req_i    (cpu_req),
    .cpu_dat_o    (cpu_dat),
    .cpu_ack_o    (cpu_ack),
    .wb_adr_o     (wb_adr),
    .ram_stb_o    (ram_stb),
    .bus_stb_o    (bus_stb),
    .global_ack_i (global_ack),
    .wb_dat_i     (wb_dat),
    .dma_req_i    (dma_req),
    .dma_adr18_i  (dma_adr18),
    .dma_stb_i    (dma_stb),
    .dma_ack_o    (dma_ack),
    .irq_i        (irq),
    .ivec_i       (ivec),
    .cpu_istb_i   (cpu_istb),
    .cpu_init_i   (cpu_init),
    .istb_o       (istb),
    .cpu_vec_o    (cpu_vec),
    .evnt_o       (evnt),
    .umap_i       (umap),
    .leds_o       (leds)
  );

  kdf11_checker #(
    .line_period (line_period)
  ) u_checker (
    .clk_p     (clk_p),
    .dclo      (dclo),
    .cpu_dat_i (cpu_dat),
    .cpu_ack_i (cpu_ack),
    .wb_adr_i  (wb_adr),
    .ram_stb_i (ram_stb),
    .bus_stb_i (bus_stb),
    .dma_ack_i (dma_ack),
    .istb_i    (istb),
    .cpu_vec_i (cpu_vec),
    .evnt_i    (evnt),
    .leds_i    (leds)
  );

  // ********************************************************************
  // bus roles entered and left on a falling edge
  // ********************************************************************
  task automatic cpu_access(input paddr_t adr, input word_t dat, input logic we,
                            input logic [1:0] sel, input word_t exp);
    cpu_req.adr = adr;
    cpu_req.dat = dat;
    cpu_req.we  = we;
    cpu_req.sel = sel;
    cpu_req.ios = 1'b1;  // every target here is in the i/o page
    cpu_req.stb = 1'b1;
    @(negedge clk_p);
    while (!cpu_ack) @(negedge clk_p);
    u_checker.strobe_state(1'b0, 1'b1);  // i/o page strobe only
    if (!we) u_checker.read_data(exp);  // data valid with ack
    cpu_req = '0;
  endtask

  task automatic run_dma(input uaddr_t adr18, input logic map_en, input paddr_t exp);
    umap      = map_en;
    dma_adr18 = adr18;
    dma_req   = 1'b1;
    @(negedge clk_p);
    while (!dma_ack) @(negedge clk_p);  // grant
    dma_stb = 1'b1;
    @(negedge clk_p);
    while (!global_ack) @(negedge clk_p);
    u_checker.dma_address(exp);
    u_checker.strobe_state(1'b1, 1'b0);  // memory strobe from the dma master
    dma_stb = 1'b0;
    dma_req = 1'b0;
    @(negedge clk_p);
    while (dma_ack) @(negedge clk_p);  // bus back to cpu
  endtask

  task automatic raise_irq(input logic [1:0] lines, input logic [8:0] vec,
                           input logic [1:0] exp_istb);
    irq      = lines;
    ivec     = vec;
    cpu_istb = 1'b1;
    @(negedge clk_p);
    u_checker.irq_response(exp_istb, {7'b0, vec});  // vector zero extended
    cpu_istb = 1'b0;
    irq      = '0;
  endtask

  task automatic count_events(input int periods, input int pulses);
    u_checker.event_window_open();
    repeat (periods * line_period) @(negedge clk_p);
    u_checker.event_window_close(pulses);
  endtask

  // run limit
  always @(posedge clk_p) begin
    cycles++;
    if (limit > 0 && cycles >= limit) begin
      $display("Timeout: the run did not finish within %0d cycles", limit);
      u_checker.report();
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin
    integer      seed;
    int          n_ops;
    int          gap;
    logic [23:0] op;
    paddr_t      adr;
    word_t       dat;
    paddr_t      exp;
    seed      = 32'ha27;
    dclo      = 1'b1;
    cpu_req   = '0;
    wb_dat    = '0;  // internal reads only, keeps the or-mux clean
    dma_req   = 1'b0;
    dma_adr18 = '0;
    dma_stb   = 1'b0;
    irq       = '0;
    ivec      = '0;
    cpu_istb  = 1'b0;
    cpu_init  = 1'b0;
    umap      = 1'b0;
    for (int i = 0; i < 4 * max_ops; i++) golden[i] = '0;
    $readmemh("test/kdf11_golden.mem", golden);
    n_ops = 0;
    while (n_ops < max_ops && golden[4*n_ops] != '0) n_ops++;
    limit = 2 * n_ops * 8 + 10 * line_period;

    repeat (5) @(posedge clk_p);
    @(negedge clk_p);
    u_checker.reset_state();
    dclo = 1'b0;

    for (int i = 0; i < n_ops; i++) begin
      op  = golden[4*i];
      adr = golden[4*i+1][21:0];
      dat = golden[4*i+2][15:0];
      exp = golden[4*i+3][21:0];
      gap = $random(seed) & 3;  // idle cycles between transactions
      repeat (gap) @(negedge clk_p);
      case (op[7:0])
        8'h01:   cpu_access(adr, dat, 1'b1, 2'b11, '0);
        8'h02:   cpu_access(adr, dat, 1'b1, 2'b01, '0);
        8'h03:   cpu_access(adr, dat, 1'b1, 2'b10, '0);
        8'h04:   cpu_access(adr, '0, 1'b0, 2'b11, exp[15:0]);
        8'h05:   run_dma(adr[17:0], dat[0], exp);
        8'h06:   raise_irq(adr[1:0], dat[8:0], exp[1:0]);
        8'h07:   count_events(int'(dat), int'(exp));
        8'h08:   u_checker.led_state(exp[3:0]);
        default: u_checker.fault($sformatf("unknown opcode %h in golden line %0d", op, i));
      endcase
    end

    repeat (4) @(negedge clk_p);
    u_checker.report();
    if (u_checker.failures() == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- ubm/ubm_map.sv
/*
 * unibus map: 32 mapping registers at 170200-170377
 * and translation of 18-bit dma addresses to 22 bits
 */
`timescale 1ns/1ps
`default_nettype none

module ubm_map import kdf11_pkg::*; (
  input  logic     clk_p,
  input  logic     init_i,       // bus reset
  input  logic     sel_i,
  input  cpu_req_t req_i,
  input  logic     umap_i,       // map enable from cpu
  input  logic     dma_ack_i,
  input  uaddr_t   dma_adr18_i,
  output word_t    dat_o,
  output logic     ack_o,
  output paddr_t   wb_adr_o
);

  // register file, bit 0 of each entry is always zero
  logic [7:1] ubm_l [32];  // low byte
  logic [7:0] ubm_m [32];  // middle byte
  logic [5:0] ubm_h [32];  // high part

  ubm_idx_t reg_idx;   // cpu side register
  ubm_idx_t dma_page;  // page of the dma address
  paddr_t   map_base;
  paddr_t   dma_paddr;

  assign reg_idx = req_i.adr[6:2];  // two words per register

  // ********************************************************************
  // cpu access to the map registers
  // ********************************************************************
  always_ff @(posedge clk_p) begin
    if (sel_i && req_i.we) begin
      if (!req_i.adr[1]) begin
        if (req_i.sel[0]) ubm_l[reg_idx] <= req_i.dat[7:1];
        if (req_i.sel[1]) ubm_m[reg_idx] <= req_i.dat[15:8];
      end else if (req_i.sel[0]) begin
        ubm_h[reg_idx] <= req_i.dat[5:0];  // high word, 6 bits
      end
    end else if (sel_i) begin
      if (!req_i.adr[1]) dat_o <= {ubm_m[reg_idx], ubm_l[reg_idx], 1'b0};
      else               dat_o <= {10'b0, ubm_h[reg_idx]};
    end
  end

  always_ff @(posedge clk_p) begin
    if (init_i) ack_o <= 1'b0;
    else        ack_o <= sel_i & ~ack_o;
  end

  // ********************************************************************
  // dma address translation
  // ********************************************************************
  assign dma_page = dma_adr18_i[17:13];
  assign map_base = {ubm_h[dma_page], ubm_m[dma_page], ubm_l[dma_page], 1'b0};

  always_comb begin
    if (dma_page == ubm_page_c) begin
      dma_paddr = {9'h1ff, dma_adr18_i[12:0]};       // top page into the i/o page
    end else if (umap_i) begin
      dma_paddr = map_base + {9'b0, dma_adr18_i[12:0]};
    end else begin
      dma_paddr = {4'b0, dma_adr18_i};               // unmapped, 18-bit space
    end
  end

  assign wb_adr_o = dma_ack_i ? dma_paddr : req_i.adr;  // cpu address when no dma

endmodule

`default_nettype wire

//--- verilog.f
common/kdf11_pkg.sv
hw/bus_control.sv
hw/iopage_decode.sv
hw/bdr_regs.sv
hw/line_clock.sv
ubm/ubm_map.sv
hw/kdf11_board.sv
test/kdf11_assert.sv
test/kdf11_checker.sv
test/kdf11_tb.sv
